// File: hdl/wavegen_reg_pkg.sv
`default_nettype none

package wavegen_reg_pkg;

    // AXI4-Lite byte address space of the register block
    localparam int reg_addr_width = 5;

    localparam logic [reg_addr_width-1:0] reg_ctrl      = 5'h00; // write-only
    localparam logic [reg_addr_width-1:0] reg_status    = 5'h04; // read-only
    localparam logic [reg_addr_width-1:0] reg_length    = 5'h08;
    localparam logic [reg_addr_width-1:0] reg_divider   = 5'h0C;
    localparam logic [reg_addr_width-1:0] reg_default   = 5'h10; // idle word
    localparam logic [reg_addr_width-1:0] reg_wave_addr = 5'h14; // load pointer
    localparam logic [reg_addr_width-1:0] reg_wave_data = 5'h18; // write-only

    // CTRL bits
    localparam int ctrl_start_bit = 0;
    localparam int ctrl_stop_bit  = 1;

    // STATUS bits
    localparam int status_busy_bit = 0;

    // smallest divider the sequencer can follow
    localparam logic [31:0] divider_min = 32'd2;

    // every access is answered with OKAY
    localparam logic [1:0] axil_resp_okay = 2'b00;

endpackage

`default_nettype wire

// File: hdl/wavegen_sample_pkg.sv
`default_nettype none

package wavegen_sample_pkg;

    // one channel as software writes it, two's complement
    typedef logic signed [15:0] chan_sample_t;

    // a waveform word is stored as a plain 32-bit value but played
    // back as two channel samples
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            chan_sample_t ch1; // upper half
            chan_sample_t ch0; // lower half
        } pair;
    } wave_word_u;

endpackage

`default_nettype wire

// File: hdl/axil_wave_regs.sv
`default_nettype none

module axil_wave_regs
    import wavegen_reg_pkg::*;
    import wavegen_sample_pkg::*;
#(
    parameter int ADDR_WIDTH = 11
) (
    input  wire                        axi_clock,
    input  wire                        rst_i,
    // write address / data / response
    input  wire [reg_addr_width-1:0]   s_awaddr_i,
    input  wire                        s_awvalid_i,
    output logic                       s_awready_o,
    input  wire [31:0]                 s_wdata_i,
    input  wire [3:0]                  s_wstrb_i,
    input  wire                        s_wvalid_i,
    output logic                       s_wready_o,
    output logic [1:0]                 s_bresp_o,
    output logic                       s_bvalid_o,
    input  wire                        s_bready_i,
    // read address / data
    input  wire [reg_addr_width-1:0]   s_araddr_i,
    input  wire                        s_arvalid_i,
    output logic                       s_arready_o,
    output logic [31:0]                s_rdata_o,
    output logic [1:0]                 s_rresp_o,
    output logic                       s_rvalid_o,
    input  wire                        s_rready_i,
    // to the sequencer
    output logic                       start_o,
    output logic                       stop_o,
    output logic [ADDR_WIDTH:0]        length_o,
    output logic [31:0]                divider_o,
    output wave_word_u                 default_word_o,
    input  wire                        busy_i,
    // to the waveform memory
    output logic                       wave_we_o,
    output logic [ADDR_WIDTH-1:0]      wave_waddr_o,
    output logic [31:0]                wave_wdata_o
);

    logic                  wr_ready_q; // shared by aw and w channels
    logic                  wr_fire;
    logic                  rd_fire;
    logic [ADDR_WIDTH:0]   length_q;
    logic [31:0]           divider_q;
    wave_word_u            default_q;
    logic [ADDR_WIDTH-1:0] wave_addr_q;
    logic [31:0]           rdata_mux;

    assign s_awready_o = wr_ready_q;
    assign s_wready_o  = wr_ready_q;
    assign s_bresp_o   = axil_resp_okay;
    assign s_rresp_o   = axil_resp_okay;

    assign wr_fire = wr_ready_q & s_awvalid_i & s_wvalid_i;
    assign rd_fire = s_arready_o & s_arvalid_i;

    // write channel, one request in flight
    always_ff @(posedge axi_clock) begin
        if (rst_i) begin
            wr_ready_q <= 1'b0;
            s_bvalid_o <= 1'b0;
        end else begin
            wr_ready_q <= ~wr_ready_q & s_awvalid_i & s_wvalid_i & ~s_bvalid_o;
            if (wr_fire) begin
                s_bvalid_o <= 1'b1;
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi_clock) begin
        if (rst_i) begin
            start_o     <= 1'b0;
            stop_o      <= 1'b0;
            length_q    <= '0;
            divider_q   <= divider_min;
            default_q   <= '0;
            wave_addr_q <= '0;
        end else begin
            start_o <= wr_fire && (s_awaddr_i == reg_ctrl) && s_wdata_i[ctrl_start_bit];
            stop_o  <= wr_fire && (s_awaddr_i == reg_ctrl) && s_wdata_i[ctrl_stop_bit];
            if (wr_fire) begin
                case (s_awaddr_i)
                    reg_length:    length_q <= s_wdata_i[ADDR_WIDTH:0];
                    reg_divider:   divider_q <= (s_wdata_i < divider_min) ? divider_min
                                                                          : s_wdata_i;
                    reg_default:   default_q.raw <= s_wdata_i;
                    reg_wave_addr: wave_addr_q <= s_wdata_i[ADDR_WIDTH-1:0];
                    reg_wave_data: wave_addr_q <= wave_addr_q + ADDR_WIDTH'(1); // auto-inc
                    default: ;
                endcase
            end
        end
    end

    // memory write goes out with the accepted data beat
    assign wave_we_o    = wr_fire && (s_awaddr_i == reg_wave_data);
    assign wave_waddr_o = wave_addr_q;
    assign wave_wdata_o = s_wdata_i;

    assign length_o       = length_q;
    assign divider_o      = divider_q;
    assign default_word_o = default_q;

    always_comb begin
        rdata_mux = '0; // unmapped and write-only offsets
        case (s_araddr_i)
            reg_status:    rdata_mux[status_busy_bit] = busy_i;
            reg_length:    rdata_mux = 32'(length_q);
            reg_divider:   rdata_mux = divider_q;
            reg_default:   rdata_mux = default_q.raw;
            reg_wave_addr: rdata_mux = 32'(wave_addr_q);
            default: ;
        endcase
    end

    // read channel
    always_ff @(posedge axi_clock) begin
        if (rst_i) begin
            s_arready_o <= 1'b0;
            s_rvalid_o  <= 1'b0;
        end else begin
            s_arready_o <= ~s_arready_o & s_arvalid_i & ~s_rvalid_o;
            if (rd_fire) begin
                s_rvalid_o <= 1'b1;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi_clock) begin
        if (rd_fire) begin
            s_rdata_o <= rdata_mux;
        end
    end

    // responses only ever follow an accepted request
    assert property (@(posedge axi_clock) disable iff (rst_i)
        $rose(s_bvalid_o) |-> $past(wr_fire))
        else $error("bvalid without accepted write");
    assert property (@(posedge axi_clock) disable iff (rst_i)
        $rose(s_rvalid_o) |-> $past(rd_fire))
        else $error("rvalid without accepted read");

    // whole-word writes only, byte lanes are not decoded
    assert property (@(posedge axi_clock) disable iff (rst_i)
        wr_fire |-> s_wstrb_i == 4'hF)
        else $error("partial write strobe not supported");

endmodule

`default_nettype wire

// File: hdl/wave_ram.sv
`default_nettype none

module wave_ram #(
    parameter int ADDR_WIDTH = 11
) (
    input  wire                  axi_clock,
    // write side, from the register block
    input  wire                  we_i,
    input  wire [ADDR_WIDTH-1:0] waddr_i,
    input  wire [31:0]           wdata_i,
    // read side, from the sequencer
    input  wire                  rd_en_i,
    input  wire [ADDR_WIDTH-1:0] raddr_i,
    output logic [31:0]          rdata_o
);

    localparam int depth = 1 << ADDR_WIDTH;

    logic [31:0] mem [0:depth-1];

    // ports are independent, the sequencer never reads a word
    // in the cycle software writes it
    always_ff @(posedge axi_clock) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge axi_clock) begin
        if (rd_en_i) begin
            rdata_o <= mem[raddr_i]; // one cycle latency
        end
    end

endmodule

`default_nettype wire

// File: hdl/wave_sequencer.sv
`default_nettype none

module wave_sequencer
    import wavegen_sample_pkg::*;
#(
    parameter int ADDR_WIDTH = 11
) (
    input  wire                   axi_clock,
    input  wire                   rst_i,
    input  wire                   start_i,
    input  wire                   stop_i,
    input  wire [ADDR_WIDTH:0]    length_i,
    input  wire [31:0]            divider_i,
    input  wire wave_word_u       default_word_i,
    output logic                  busy_o,
    output logic                  rd_en_o,
    output logic [ADDR_WIDTH-1:0] rd_addr_o,
    input  wire [31:0]            rd_data_i,
    output wave_word_u            sample_word_o
);

    logic        run_q;     // rate counter active
    logic [31:0] rate_cnt;
    logic        rd_valid;  // rd_en delayed by the memory latency
    logic        fin_q;     // end marker, travels like a read
    logic        fin_d;
    logic        rate_tick;
    logic        last_addr;

    assign rate_tick = (rate_cnt + 32'd1) >= divider_i;
    assign last_addr = ({1'b0, rd_addr_o} + (ADDR_WIDTH+1)'(1)) >= length_i;

    always_ff @(posedge axi_clock) begin
        if (rst_i) begin
            busy_o    <= 1'b0;
            run_q     <= 1'b0;
            rate_cnt  <= '0;
            rd_en_o   <= 1'b0;
            rd_addr_o <= '0;
            rd_valid  <= 1'b0;
            fin_q     <= 1'b0;
            fin_d     <= 1'b0;
        end else begin
            rd_en_o  <= 1'b0;
            fin_q    <= 1'b0;
            rd_valid <= rd_en_o;
            fin_d    <= fin_q;
            if (start_i && length_i != '0) begin
                // also restarts a running waveform
                busy_o    <= 1'b1;
                run_q     <= 1'b1;
                rate_cnt  <= '0;
                rd_addr_o <= '0;
                rd_en_o   <= 1'b1;
                fin_d     <= 1'b0;
            end else if (stop_i || fin_d) begin
                busy_o <= 1'b0;
                run_q  <= 1'b0;
            end else if (run_q) begin
                if (rate_tick) begin
                    rate_cnt <= '0;
                    if (last_addr) begin
                        run_q <= 1'b0;
                        fin_q <= 1'b1; // default shows one period after last sample
                    end else begin
                        rd_addr_o <= rd_addr_o + ADDR_WIDTH'(1);
                        rd_en_o   <= 1'b1;
                    end
                end else begin
                    rate_cnt <= rate_cnt + 32'd1;
                end
            end
        end
    end

    // hold register, reads landing after a stop are dropped
    always_ff @(posedge axi_clock) begin
        if (rst_i) begin
            sample_word_o <= '0;
        end else if (!busy_o || stop_i || fin_d) begin
            sample_word_o <= default_word_i;
        end else if (rd_valid) begin
            sample_word_o.raw <= rd_data_i;
        end
    end

    assert property (@(posedge axi_clock) disable iff (rst_i)
        busy_o |-> {1'b0, rd_addr_o} < length_i)
        else $error("read address past programmed length");

endmodule

`default_nettype wire

// File: hdl/dac_iq_interleave.sv
`default_nettype none

module dac_iq_interleave
    import wavegen_sample_pkg::*;
#(
    parameter int DAC_WIDTH = 14
) (
    input  wire                  axi_clock,
    input  wire                  rst_i,
    input  wire wave_word_u      sample_word_i,
    output logic                 dac_clk_o,
    output logic                 dac_rst_o,
    output logic                 dac_sel_o,  // high while ch0 is on the bus
    output logic                 dac_wrt_o,
    output logic [DAC_WIDTH-1:0] dac_dat_o
);

    logic       phase_q;
    wave_word_u latch_q; // keeps ch1 stable for its slot

    // two's complement to offset binary on the DAC width
    function automatic logic [DAC_WIDTH-1:0] to_offset_bin(input chan_sample_t s);
        return {~s[DAC_WIDTH-1], s[DAC_WIDTH-2:0]};
    endfunction

    assign dac_clk_o = phase_q;

    always_ff @(posedge axi_clock) begin
        if (rst_i) begin
            phase_q   <= 1'b0;
            dac_sel_o <= 1'b0;
            dac_wrt_o <= 1'b0;
            dac_rst_o <= 1'b1;
        end else begin
            phase_q   <= ~phase_q;
            dac_sel_o <= ~phase_q;
            dac_wrt_o <= 1'b1;
            dac_rst_o <= 1'b0; // released one cycle after rst_i
        end
    end

    always_ff @(posedge axi_clock) begin
        if (!phase_q) begin
            latch_q   <= sample_word_i;
            dac_dat_o <= to_offset_bin(sample_word_i.pair.ch0);
        end else begin
            dac_dat_o <= to_offset_bin(latch_q.pair.ch1);
        end
    end

    assert property (@(posedge axi_clock) disable iff (rst_i)
        !$past(rst_i) |-> dac_sel_o != $past(dac_sel_o))
        else $error("dac_sel_o did not alternate");

endmodule

`default_nettype wire

// File: hdl/wavegen_top.sv
`default_nettype none

module wavegen_top
    import wavegen_reg_pkg::*;
    import wavegen_sample_pkg::*;
#(
    parameter int ADDR_WIDTH = 11,
    parameter int DAC_WIDTH  = 14
) (
    input  wire                        axi_clock,
    input  wire                        rst_i,
    input  wire [reg_addr_width-1:0]   s_awaddr_i,
    input  wire                        s_awvalid_i,
    output logic                       s_awready_o,
    input  wire [31:0]                 s_wdata_i,
    input  wire [3:0]                  s_wstrb_i,
    input  wire                        s_wvalid_i,
    output logic                       s_wready_o,
    output logic [1:0]                 s_bresp_o,
    output logic                       s_bvalid_o,
    input  wire                        s_bready_i,
    input  wire [reg_addr_width-1:0]   s_araddr_i,
    input  wire                        s_arvalid_i,
    output logic                       s_arready_o,
    output logic [31:0]                s_rdata_o,
    output logic [1:0]                 s_rresp_o,
    output logic                       s_rvalid_o,
    input  wire                        s_rready_i,
    output logic                       dac_clk_o,
    output logic                       dac_rst_o,
    output logic                       dac_sel_o,
    output logic                       dac_wrt_o,
    output logic [DAC_WIDTH-1:0]       dac_dat_o,
    output logic [7:0]                 led_o
);

    logic                  start;
    logic                  stop;
    logic [ADDR_WIDTH:0]   length;
    logic [31:0]           divider;
    wave_word_u            default_word;
    logic                  busy;
    logic                  wave_we;
    logic [ADDR_WIDTH-1:0] wave_waddr;
    logic [31:0]           wave_wdata;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [31:0]           rd_data;
    wave_word_u            sample_word;

    axil_wave_regs #(.ADDR_WIDTH(ADDR_WIDTH)) u_regs (
        .axi_clock(axi_clock), .rst_i(rst_i),
        .s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
        .s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wvalid_i(s_wvalid_i),
        .s_wready_o(s_wready_o), .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o),
        .s_bready_i(s_bready_i), .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i),
        .s_arready_o(s_arready_o), .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o),
        .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
        .start_o(start), .stop_o(stop), .length_o(length), .divider_o(divider),
        .default_word_o(default_word), .busy_i(busy),
        .wave_we_o(wave_we), .wave_waddr_o(wave_waddr), .wave_wdata_o(wave_wdata)
    );

    wave_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
        .axi_clock(axi_clock),
        .we_i(wave_we), .waddr_i(wave_waddr), .wdata_i(wave_wdata),
        .rd_en_i(rd_en), .raddr_i(rd_addr), .rdata_o(rd_data)
    );

    wave_sequencer #(.ADDR_WIDTH(ADDR_WIDTH)) u_seq (
        .axi_clock(axi_clock), .rst_i(rst_i),
        .start_i(start), .stop_i(stop), .length_i(length), .divider_i(divider),
        .default_word_i(default_word), .busy_o(busy),
        .rd_en_o(rd_en), .rd_addr_o(rd_addr), .rd_data_i(rd_data),
        .sample_word_o(sample_word)
    );

    dac_iq_interleave #(.DAC_WIDTH(DAC_WIDTH)) u_dac (
        .axi_clock(axi_clock), .rst_i(rst_i), .sample_word_i(sample_word),
        .dac_clk_o(dac_clk_o), .dac_rst_o(dac_rst_o), .dac_sel_o(dac_sel_o),
        .dac_wrt_o(dac_wrt_o), .dac_dat_o(dac_dat_o)
    );

    assign led_o = {dac_dat_o[6:0], busy}; // busy on led 0

endmodule

`default_nettype wire

// File: dv/wavegen_tb.sv
`default_nettype none

module wavegen_tb
    import wavegen_reg_pkg::*;
();

    localparam int axi_timeout  = 50;   // cycles per handshake wait
    localparam int pair_timeout = 200;  // cycles to see a pair on the DAC
    localparam int poll_limit   = 400;  // STATUS reads while playing

    localparam logic [1:0] op_write = 2'd0;
    localparam logic [1:0] op_read  = 2'd1;
    localparam logic [1:0] op_play  = 2'd2; // data is the divider
    localparam logic [1:0] op_stop  = 2'd3; // data is the divider, expected the length

    typedef struct packed {
        logic [1:0]  op;
        logic [4:0]  offset;
        logic [31:0] data;
        logic [31:0] expected;
    } step_t;

    logic        axi_clock;
    logic        rst;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        dac_clk_o;
    logic        dac_rst_o;
    logic        dac_sel_o;
    logic        dac_wrt_o;
    logic [13:0] dac_dat_o;
    logic [7:0]  led_o;

    step_t       steps[$];
    logic [31:0] play_words[$];
    logic [27:0] pairs[$];      // {ch1, ch0} as seen on the DAC bus
    logic        have_ch0;
    logic [13:0] ch0_q;
    logic        rst_q;         // rst one cycle late
    logic        phase_exp;     // expected DAC phase, ch0 slot when high
    logic [31:0] default_word;

    wavegen_top #(.ADDR_WIDTH(11), .DAC_WIDTH(14)) uut (
        .axi_clock(axi_clock), .rst_i(rst),
        .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
        .s_wdata_i(wdata), .s_wstrb_i(4'hF), .s_wvalid_i(wvalid), .s_wready_o(wready),
        .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
        .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
        .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
        .dac_clk_o(dac_clk_o), .dac_rst_o(dac_rst_o), .dac_sel_o(dac_sel_o),
        .dac_wrt_o(dac_wrt_o), .dac_dat_o(dac_dat_o), .led_o(led_o)
    );

    always #20 axi_clock = ~axi_clock;

    // ch0 goes out with dac_sel_o high, ch1 in the cycle after
    always @(posedge axi_clock) begin
        rst_q <= rst;
        if (rst) begin
            have_ch0  <= 1'b0;
            phase_exp <= 1'b0;
        end else begin
            // DAC control pins lag the reset release by one cycle
            check_value("dac_rst_o", 32'(dac_rst_o), 32'(rst_q));
            check_value("dac_wrt_o", 32'(dac_wrt_o), 32'(!rst_q));
            check_value("dac_clk_o", 32'(dac_clk_o), 32'(phase_exp));
            check_value("dac_sel_o", 32'(dac_sel_o), 32'(phase_exp));
            check_value("led_o[7:1]", 32'(led_o[7:1]), 32'(dac_dat_o[6:0]));
            phase_exp <= !phase_exp;
            if (dac_sel_o) begin
                ch0_q    <= dac_dat_o;
                have_ch0 <= 1'b1;
            end else if (have_ch0) begin
                have_ch0 <= 1'b0;
                if (pairs.size() == 0 || pairs[$] !== {dac_dat_o, ch0_q}) begin
                    pairs.push_back({dac_dat_o, ch0_q}); // repeats dropped
                end
            end
        end
    end

    // sign bit flipped on the low 14 bits of each half
    function automatic logic [27:0] dac_pair(input logic [31:0] w);
        return {w[29:16] ^ 14'h2000, w[13:0] ^ 14'h2000};
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        return {16'(a) ^ 16'h1357, 16'(a) + 16'h0101};
    endfunction

    function automatic step_t make_step(input logic [1:0] op, input logic [4:0] off,
                                        input logic [31:0] data, input logic [31:0] exp);
        return {op, off, data, exp};
    endfunction

    function automatic string reg_name(input logic [4:0] off);
        case (off)
            reg_ctrl:      return "s_rdata_o CTRL";
            reg_status:    return "s_rdata_o STATUS";
            reg_length:    return "s_rdata_o LENGTH";
            reg_divider:   return "s_rdata_o DIVIDER";
            reg_default:   return "s_rdata_o DEFAULT";
            reg_wave_addr: return "s_rdata_o WAVE_ADDR";
            reg_wave_data: return "s_rdata_o WAVE_DATA";
            default:       return "s_rdata_o unmapped";
        endcase
    endfunction

    task automatic fail_now();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout waiting for %s", what);
        fail_now();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error %s expected 0x%0h got 0x%0h", name, exp, got);
            fail_now();
        end
    endtask

    task automatic check_pair(input logic [27:0] got, input logic [27:0] exp);
        check_value("dac_dat_o ch0", 32'(got[13:0]), 32'(exp[13:0]));
        check_value("dac_dat_o ch1", 32'(got[27:14]), 32'(exp[27:14]));
    endtask

    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
        int n;
        @(posedge axi_clock);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        n = 0;
        do begin
            @(posedge axi_clock);
            n++;
        end while (!awready && n < axi_timeout);
        if (!awready) timeout_fail("awready");
        check_value("s_wready_o", 32'(wready), 32'd1);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge axi_clock);
            n++;
        end while (!bvalid && n < axi_timeout);
        if (!bvalid) timeout_fail("bvalid");
        check_value("s_bresp_o", 32'(bresp), 32'(axil_resp_okay));
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
        int n;
        @(posedge axi_clock);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        n = 0;
        do begin
            @(posedge axi_clock);
            n++;
        end while (!arready && n < axi_timeout);
        if (!arready) timeout_fail("arready");
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge axi_clock);
            n++;
        end while (!rvalid && n < axi_timeout);
        if (!rvalid) timeout_fail("rvalid");
        data = rdata;
        check_value("s_rresp_o", 32'(rresp), 32'(axil_resp_okay));
        rready <= 1'b0;
    endtask

    task automatic wait_for_pair(input logic [27:0] exp, input string what);
        int   n;
        logic found;
        n = 0;
        found = 1'b0;
        while (!found && n < pair_timeout) begin
            @(negedge axi_clock);
            found = pairs.size() > 0 && pairs[$] === exp;
            n++;
        end
        if (!found) begin
            if (pairs.size() > 0) check_pair(pairs[$], exp); // shows the wrong value
            timeout_fail(what);
        end
    endtask

    task automatic wait_idle();
        logic [31:0] d;
        int          polls;
        polls = 0;
        do begin
            axi_read(reg_status, d);
            polls++;
        end while (d[status_busy_bit] && polls < poll_limit);
        if (d[status_busy_bit]) timeout_fail("busy to fall");
        check_value("led_o[0]", 32'(led_o[0]), 32'd0);
    endtask

    // loads play_words from address 0 and plays them once
    task automatic play_check(input logic [31:0] div);
        logic [31:0] d;
        logic [27:0] exp_q[$];
        axi_write(reg_wave_addr, 32'd0);
        foreach (play_words[w]) axi_write(reg_wave_data, play_words[w]);
        axi_write(reg_length, play_words.size());
        axi_write(reg_divider, div);
        @(negedge axi_clock);
        pairs.delete();
        axi_write(reg_ctrl, 32'd1 << ctrl_start_bit);
        if (play_words.size() * div >= 24) begin // long enough to catch busy
            axi_read(reg_status, d);
            check_value("s_rdata_o STATUS busy", 32'(d[status_busy_bit]), 32'd1);
            check_value("led_o[0]", 32'(led_o[0]), 32'd1);
        end
        wait_idle();
        wait_for_pair(dac_pair(default_word), "DEFAULT after playback");
        exp_q.push_back(dac_pair(default_word));
        foreach (play_words[w]) exp_q.push_back(dac_pair(play_words[w]));
        exp_q.push_back(dac_pair(default_word));
        check_value("dac pair count", pairs.size(), exp_q.size());
        foreach (exp_q[p]) check_pair(pairs[p], exp_q[p]);
    endtask

    task automatic stop_check(input logic [31:0] div, input logic [31:0] len);
        logic [31:0] d;
        int          a;
        axi_write(reg_wave_addr, 32'd0);
        for (a = 0; a < len; a++) axi_write(reg_wave_data, fill_word(a));
        axi_write(reg_length, len);
        axi_write(reg_divider, div);
        axi_write(reg_ctrl, 32'd1 << ctrl_start_bit);
        axi_read(reg_status, d);
        check_value("s_rdata_o STATUS busy", 32'(d[status_busy_bit]), 32'd1);
        axi_write(reg_ctrl, 32'd1 << ctrl_stop_bit);
        axi_read(reg_status, d);
        check_value("s_rdata_o STATUS busy", 32'(d[status_busy_bit]), 32'd0);
        check_value("led_o[0]", 32'(led_o[0]), 32'd0);
        @(negedge axi_clock);
        pairs.delete();
        wait_for_pair(dac_pair(default_word), "DEFAULT after stop");
    endtask

    task automatic build_steps();
        // op, offset, data, expected
        steps.push_back(make_step(op_read,  reg_status,    32'h0,         32'h0));
        steps.push_back(make_step(op_read,  5'h1C,         32'h0,         32'h0));
        steps.push_back(make_step(op_write, reg_length,    32'h123,       32'h0));
        steps.push_back(make_step(op_read,  reg_length,    32'h0,         32'h123));
        steps.push_back(make_step(op_write, reg_divider,   32'h0,         32'h0));
        steps.push_back(make_step(op_read,  reg_divider,   32'h0,         32'h2));
        steps.push_back(make_step(op_write, reg_divider,   32'h1,         32'h0));
        steps.push_back(make_step(op_read,  reg_divider,   32'h0,         32'h2));
        steps.push_back(make_step(op_write, reg_divider,   32'h7,         32'h0));
        steps.push_back(make_step(op_read,  reg_divider,   32'h0,         32'h7));
        steps.push_back(make_step(op_write, reg_wave_addr, 32'h55,        32'h0));
        steps.push_back(make_step(op_read,  reg_wave_addr, 32'h0,         32'h55));
        steps.push_back(make_step(op_write, reg_wave_data, 32'hDEADBEEF,  32'h0));
        steps.push_back(make_step(op_read,  reg_wave_addr, 32'h0,         32'h56));
        steps.push_back(make_step(op_read,  reg_wave_data, 32'h0,         32'h0));
        steps.push_back(make_step(op_read,  reg_ctrl,      32'h0,         32'h0));
        steps.push_back(make_step(op_write, reg_default,   32'h1234E001,  32'h0));
        steps.push_back(make_step(op_read,  reg_default,   32'h0,         32'h1234E001));
        steps.push_back(make_step(op_write, reg_default,   32'h0A5A3FFF,  32'h0));
        steps.push_back(make_step(op_play,  5'h00,         32'd4,         32'h0));
        steps.push_back(make_step(op_read,  reg_status,    32'h0,         32'h0));
        steps.push_back(make_step(op_stop,  5'h00,         32'd16,        32'd64));
        steps.push_back(make_step(op_read,  reg_status,    32'h0,         32'h0));
    endtask

    initial begin
        logic [31:0] seed;
        logic [31:0] d;
        logic [31:0] w;
        logic [31:0] len;
        logic [31:0] div;
        int          run;
        int          i;
        seed = $urandom(70336);
        axi_clock    = 1'b0;
        rst          = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        default_word = '0;
        play_words   = '{32'h00000000, 32'h1FFFE000, 32'h20001FFF, 32'h0123FEDC,
                         32'hFFFF0001, 32'h7FFF8000, 32'h15552AAA, 32'hC0DE0BAD};
        build_steps();
        repeat (16) @(posedge axi_clock);
        rst <= 1'b0;

        wait_for_pair({14'h2000, 14'h2000}, "mid-scale after reset");
        check_value("led_o[0]", 32'(led_o[0]), 32'd0);
        check_value("dac_wrt_o", 32'(dac_wrt_o), 32'd1);

        foreach (steps[k]) begin
            case (steps[k].op)
                op_write: begin
                    axi_write(steps[k].offset, steps[k].data);
                    if (steps[k].offset == reg_default) begin
                        default_word = steps[k].data;
                        wait_for_pair(dac_pair(default_word), "DEFAULT on the DAC output");
                    end
                end
                op_read: begin
                    axi_read(steps[k].offset, d);
                    check_value(reg_name(steps[k].offset), d, steps[k].expected);
                end
                op_play: play_check(steps[k].data);
                op_stop: stop_check(steps[k].data, steps[k].expected);
            endcase
        end

        for (run = 0; run < 10; run++) begin
            len = 1 + $urandom % 32;
            div = 2 * (1 + $urandom % 4);
            play_words.delete();
            for (i = 0; i < len; i++) begin
                // every word must show up as a new pair
                do begin
                    w = $urandom;
                end while (dac_pair(w) == dac_pair(default_word) ||
                           (i > 0 && dac_pair(w) == dac_pair(play_words[i-1])));
                play_words.push_back(w);
            end
            play_check(div);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/wavegen_reg_pkg.sv
hdl/wavegen_sample_pkg.sv
hdl/axil_wave_regs.sv
hdl/wave_ram.sv
hdl/wave_sequencer.sv
hdl/dac_iq_interleave.sv
hdl/wavegen_top.sv
dv/wavegen_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the wavegen testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sources.f --top-module wavegen_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vwavegen_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "=== PASS ===" <<< "$sim_out"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
